// ==== project.f ====
source/bridge_pkg.sv
source/cmd_pump_in.sv
source/cache_pkt_encoder.sv
source/resp_header_fifo.sv
source/resp_pump_out.sv
source/cache_data_store.sv
source/mem_to_cache_top.sv
testbench/mem_to_cache_properties.sv
testbench/mem_to_cache_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build the bridge testbench with Verilator, run it and check the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module mem_to_cache_tb \
  -f project.f -o mem_to_cache_sim

./obj_dir/mem_to_cache_sim 2>&1 | tee sim.log

if grep -q "Test failed" sim.log || ! grep -q "Test passed" sim.log; then
  echo "simulation reported a failure, see sim.log"
  exit 1
fi
echo "simulation finished cleanly"

// ==== source/bridge_pkg.sv ====
// Memory to cache bridge types
`default_nettype none

package bridge_pkg;

  // stream and cache word geometry
  localparam int data_width_c  = 64;
  localparam int mask_width_c  = data_width_c / 8;
  localparam int word_off_c    = $clog2(mask_width_c);
  localparam int block_bytes_c = 64;
  localparam int block_words_c = block_bytes_c / mask_width_c;
  localparam int addr_width_c  = 20;

  typedef enum logic [1:0] {
    msg_rd,
    msg_wr,
    msg_amo
  } msg_type_e;

  // log2 of the byte count
  typedef enum logic [2:0] {
    size_1  = 3'd0,
    size_2  = 3'd1,
    size_4  = 3'd2,
    size_8  = 3'd3,
    size_64 = 3'd6
  } msg_size_e;

  typedef enum logic [1:0] {
    subop_store,
    subop_amoswap,
    subop_amoadd,
    subop_lr
  } msg_subop_e;

  typedef struct packed {
    msg_type_e               msg_type;
    msg_subop_e              subop;
    msg_size_e               size;
    logic [addr_width_c-1:0] addr;
  } msg_header_s;

  typedef enum logic [3:0] {
    TAGST,
    LB, LH, LW, LD, LM,
    SB, SH, SW, SD, SM,
    AMOSWAP_D,
    AMOADD_D
  } cache_opcode_e;

  typedef struct packed {
    cache_opcode_e           opcode;
    logic [addr_width_c-1:0] addr;
    logic [data_width_c-1:0] data;
    logic [mask_width_c-1:0] mask;
  } cache_pkt_s;

  // one word of a command with its own address
  typedef struct packed {
    msg_header_s             header;
    logic [addr_width_c-1:0] addr;
    logic [data_width_c-1:0] data;
  } pump_beat_s;

endpackage

`default_nettype wire

// ==== source/cache_data_store.sv ====
// Behavioral cache data store
`timescale 1ns/1ps
`default_nettype none

module cache_data_store #(
  parameter int num_lines_p      = 16,
  parameter int words_per_line_p = 8
) (
  input  wire                                  clk_i,
  input  wire                                  reset_i,
  input  bridge_pkg::cache_pkt_s               pkt_i,
  input  wire                                  pkt_v_i,
  output logic                                 pkt_ready_o,
  output logic [bridge_pkg::data_width_c-1:0]  data_o,
  output logic                                 data_v_o,
  input  wire                                  data_yumi_i
);

  import bridge_pkg::*;

  localparam int num_words_lp = num_lines_p * words_per_line_p;
  localparam int idx_w_lp     = (num_words_lp > 1) ? $clog2(num_words_lp) : 1;

  logic [data_width_c-1:0] mem_r [num_words_lp];
  logic [data_width_c-1:0] data_r;
  logic                    data_v_r;
  logic [idx_w_lp-1:0]     word_idx;
  logic [idx_w_lp-1:0]     line_base;
  logic [data_width_c-1:0] old_word;
  logic                    accept;

  assign word_idx  = pkt_i.addr[word_off_c +: idx_w_lp];
  assign line_base = idx_w_lp'((word_idx / words_per_line_p) * words_per_line_p);
  assign old_word  = mem_r[word_idx];

  // one response in flight, freed by the same cycle's yumi
  assign pkt_ready_o = ~data_v_r | data_yumi_i;
  assign accept      = pkt_v_i & pkt_ready_o;
  assign data_o      = data_r;
  assign data_v_o    = data_v_r;

  always_ff @(posedge clk_i)
  begin
    if (accept)
    begin
      data_r <= old_word;
      case (pkt_i.opcode)
        TAGST:
          for (int j = 0; j < words_per_line_p; j++)
            mem_r[line_base + idx_w_lp'(j)] <= '0;
        SB, SH, SW, SD, SM:
          for (int b = 0; b < mask_width_c; b++)
          begin
            if (pkt_i.mask[b])
              mem_r[word_idx][b*8 +: 8] <= pkt_i.data[b*8 +: 8];
          end
        AMOSWAP_D:
          mem_r[word_idx] <= pkt_i.data;
        AMOADD_D:
          mem_r[word_idx] <= old_word + pkt_i.data;
        default:
          ; // loads leave the array alone
      endcase
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      data_v_r <= 1'b0;
    else if (accept)
      data_v_r <= 1'b1;
    else if (data_yumi_i)
      data_v_r <= 1'b0;
  end

endmodule

`default_nettype wire

// ==== source/cache_pkt_encoder.sv ====
// Cache packet encoder
`timescale 1ns/1ps
`default_nettype none

module cache_pkt_encoder #(
  parameter int num_lines_p      = 16,
  parameter int words_per_line_p = 8
) (
  input  wire                     clk_i,
  input  wire                     reset_i,
  input  bridge_pkg::pump_beat_s  beat_i,
  input  wire                     beat_v_i,
  output logic                    beat_yumi_o,
  input  wire                     beat_new_i,
  output logic                    hdr_push_o,
  input  wire                     hdr_full_i,
  output bridge_pkg::cache_pkt_s  pkt_o,
  output logic                    pkt_v_o,
  input  wire                     pkt_ready_i,
  input  wire                     clear_resp_v_i,
  output logic                    clear_resp_yumi_o
);

  import bridge_pkg::*;

  localparam int clear_num_lp = num_lines_p * words_per_line_p;
  localparam int cnt_w_lp     = $clog2(clear_num_lp + 1);
  localparam logic [cnt_w_lp-1:0] clear_last_lp = cnt_w_lp'(clear_num_lp);

  typedef enum logic [1:0] {
    RESET,
    CLEAR_TAG,
    READY
  } enc_state_e;

  enc_state_e              state_r, state_n;
  logic [cnt_w_lp-1:0]     sent_r, sent_n;
  logic [cnt_w_lp-1:0]     recv_r, recv_n;
  logic [data_width_c-1:0] rep_data;
  logic [mask_width_c-1:0] mask;
  cache_opcode_e           opcode;
  msg_header_s             hdr;

  assign hdr = beat_i.header;

  // narrow stores are replicated across the word, the mask picks the lane
  always_comb
  begin
    case (hdr.size)
      size_1:
      begin
        rep_data = {8{beat_i.data[7:0]}};
        mask     = mask_width_c'(1) << beat_i.addr[2:0];
      end
      size_2:
      begin
        rep_data = {4{beat_i.data[15:0]}};
        mask     = mask_width_c'(2'b11) << {beat_i.addr[2:1], 1'b0};
      end
      size_4:
      begin
        rep_data = {2{beat_i.data[31:0]}};
        mask     = mask_width_c'(4'hf) << {beat_i.addr[2], 2'b00};
      end
      default:
      begin
        rep_data = beat_i.data;
        mask     = '1;
      end
    endcase
  end

  always_comb
  begin
    case (hdr.msg_type)
      msg_rd:
        case (hdr.size)
          size_1:  opcode = LB;
          size_2:  opcode = LH;
          size_4:  opcode = LW;
          size_8:  opcode = LD;
          default: opcode = LM;
        endcase
      msg_wr:
        case (hdr.size)
          size_1:  opcode = SB;
          size_2:  opcode = SH;
          size_4:  opcode = SW;
          size_8:  opcode = SD;
          default: opcode = SM;
        endcase
      default:
        case (hdr.subop)
          subop_amoswap: opcode = AMOSWAP_D;
          subop_amoadd:  opcode = AMOADD_D;
          default:       opcode = SD;
        endcase
    endcase
  end

  always_comb
  begin
    state_n           = state_r;
    sent_n            = sent_r;
    recv_n            = recv_r;
    pkt_o             = '0;
    pkt_v_o           = 1'b0;
    beat_yumi_o       = 1'b0;
    clear_resp_yumi_o = 1'b0;
    case (state_r)
      RESET:
        state_n = CLEAR_TAG;
      CLEAR_TAG:
      begin
        // one tag store per word index, each clears its whole line
        pkt_o.opcode      = TAGST;
        pkt_o.addr        = addr_width_c'({sent_r, {word_off_c{1'b0}}});
        pkt_v_o           = (sent_r != clear_last_lp);
        clear_resp_yumi_o = clear_resp_v_i;
        if (pkt_v_o && pkt_ready_i)
          sent_n = sent_r + 1'b1;
        if (clear_resp_v_i)
          recv_n = recv_r + 1'b1;
        if ((sent_r == clear_last_lp) && (recv_r == clear_last_lp))
          state_n = READY;
      end
      default:
      begin
        pkt_o.opcode = opcode;
        pkt_o.addr   = beat_i.addr;
        pkt_o.data   = rep_data;
        pkt_o.mask   = mask;
        // hold a new message back while the header FIFO is full
        pkt_v_o      = beat_v_i & ~(beat_new_i & hdr_full_i);
        beat_yumi_o  = pkt_v_o & pkt_ready_i;
      end
    endcase
  end

  assign hdr_push_o = beat_yumi_o & beat_new_i;

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      state_r <= RESET;
      sent_r  <= '0;
      recv_r  <= '0;
    end
    else
    begin
      state_r <= state_n;
      sent_r  <= sent_n;
      recv_r  <= recv_n;
    end
  end

endmodule

`default_nettype wire

// ==== source/cmd_pump_in.sv ====
// Command stream pump
`timescale 1ns/1ps
`default_nettype none

module cmd_pump_in (
  input  wire                                  clk_i,
  input  wire                                  reset_i,
  input  bridge_pkg::msg_header_s              cmd_header_i,
  input  wire [bridge_pkg::data_width_c-1:0]   cmd_data_i,
  input  wire                                  cmd_v_i,
  input  wire                                  cmd_last_i,
  output logic                                 cmd_ready_and_o,
  output bridge_pkg::pump_beat_s               beat_o,
  output logic                                 beat_v_o,
  input  wire                                  beat_yumi_i,
  output logic                                 beat_new_o,
  output logic                                 beat_done_o
);

  import bridge_pkg::*;

  localparam int blk_off_lp = $clog2(block_bytes_c);
  localparam int cnt_w_lp   = blk_off_lp - word_off_c;
  localparam logic [cnt_w_lp-1:0] cnt_last_lp = cnt_w_lp'(block_words_c - 1);

  logic [cnt_w_lp-1:0] cnt_r;
  logic                is_block;
  logic                rd_block;
  logic                last_word;

  assign is_block  = (cmd_header_i.size == size_64);
  assign rd_block  = is_block && (cmd_header_i.msg_type == msg_rd);
  assign last_word = (cnt_r == cnt_last_lp);

  // a block read is unrolled from one incoming beat
  assign beat_v_o        = cmd_v_i;
  assign beat_new_o      = (cnt_r == '0);
  assign beat_done_o     = rd_block ? last_word : cmd_last_i;
  assign cmd_ready_and_o = beat_yumi_i & (~rd_block | last_word);

  always_comb
  begin
    beat_o.header = cmd_header_i;
    beat_o.data   = cmd_data_i;
    if (is_block)
      beat_o.addr = {cmd_header_i.addr[addr_width_c-1:blk_off_lp], cnt_r,
                     {word_off_c{1'b0}}};
    else
      beat_o.addr = cmd_header_i.addr;
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      cnt_r <= '0;
    else if (beat_yumi_i && is_block)
      cnt_r <= beat_done_o ? '0 : cnt_r + 1'b1;
  end

endmodule

`default_nettype wire

// ==== source/mem_to_cache_top.sv ====
// Memory to cache bridge top
`timescale 1ns/1ps
`default_nettype none

module mem_to_cache_top #(
  parameter int num_lines_p      = 16,
  parameter int resp_fifo_els_p  = 4,
  parameter int words_per_line_p = 8
) (
  input  wire                                  clk_i,
  input  wire                                  reset_i,
  input  bridge_pkg::msg_header_s              cmd_header_i,
  input  wire [bridge_pkg::data_width_c-1:0]   cmd_data_i,
  input  wire                                  cmd_v_i,
  input  wire                                  cmd_last_i,
  output logic                                 cmd_ready_and_o,
  output bridge_pkg::msg_header_s              resp_header_o,
  output logic [bridge_pkg::data_width_c-1:0]  resp_data_o,
  output logic                                 resp_v_o,
  output logic                                 resp_last_o,
  input  wire                                  resp_ready_and_i
);

  import bridge_pkg::*;

  pump_beat_s              beat;
  logic                    beat_v, beat_yumi, beat_new;
  msg_header_s             fifo_hdr;
  logic                    hdr_push, hdr_full, hdr_v, hdr_pop;
  cache_pkt_s              pkt;
  logic                    pkt_v, pkt_ready;
  logic [data_width_c-1:0] store_data;
  logic                    store_v, word_yumi, clear_yumi;

  // the encoder drains the store itself during the clear sequence
  wire store_yumi = word_yumi | clear_yumi;

  cmd_pump_in cmd_pump_in_inst (
    .clk_i, .reset_i, .cmd_header_i, .cmd_data_i, .cmd_v_i, .cmd_last_i,
    .cmd_ready_and_o, .beat_o(beat), .beat_v_o(beat_v), .beat_yumi_i(beat_yumi),
    .beat_new_o(beat_new), .beat_done_o());

  cache_pkt_encoder #(.num_lines_p(num_lines_p), .words_per_line_p(words_per_line_p))
    cache_pkt_encoder_inst (
    .clk_i, .reset_i, .beat_i(beat), .beat_v_i(beat_v), .beat_yumi_o(beat_yumi),
    .beat_new_i(beat_new), .hdr_push_o(hdr_push), .hdr_full_i(hdr_full),
    .pkt_o(pkt), .pkt_v_o(pkt_v), .pkt_ready_i(pkt_ready),
    .clear_resp_v_i(store_v), .clear_resp_yumi_o(clear_yumi));

  resp_header_fifo #(.resp_fifo_els_p(resp_fifo_els_p)) resp_header_fifo_inst (
    .clk_i, .reset_i, .hdr_i(beat.header), .push_i(hdr_push), .full_o(hdr_full),
    .hdr_o(fifo_hdr), .v_o(hdr_v), .pop_i(hdr_pop));

  resp_pump_out #(.words_per_line_p(words_per_line_p)) resp_pump_out_inst (
    .clk_i, .reset_i, .hdr_i(fifo_hdr), .hdr_v_i(hdr_v), .hdr_pop_o(hdr_pop),
    .word_i(store_data), .word_v_i(store_v), .word_yumi_o(word_yumi),
    .resp_header_o, .resp_data_o, .resp_v_o, .resp_last_o, .resp_ready_and_i);

  cache_data_store #(.num_lines_p(num_lines_p), .words_per_line_p(words_per_line_p))
    cache_data_store_inst (
    .clk_i, .reset_i, .pkt_i(pkt), .pkt_v_i(pkt_v), .pkt_ready_o(pkt_ready),
    .data_o(store_data), .data_v_o(store_v), .data_yumi_i(store_yumi));

endmodule

`default_nettype wire

// ==== source/resp_header_fifo.sv ====
// Response header FIFO
`timescale 1ns/1ps
`default_nettype none

module resp_header_fifo #(
  parameter int resp_fifo_els_p = 4
) (
  input  wire                      clk_i,
  input  wire                      reset_i,
  input  bridge_pkg::msg_header_s  hdr_i,
  input  wire                      push_i,
  output logic                     full_o,
  output bridge_pkg::msg_header_s  hdr_o,
  output logic                     v_o,
  input  wire                      pop_i
);

  import bridge_pkg::*;

  localparam int ptr_w_lp = (resp_fifo_els_p > 1) ? $clog2(resp_fifo_els_p) : 1;
  localparam int cnt_w_lp = $clog2(resp_fifo_els_p + 1);
  localparam logic [ptr_w_lp-1:0] ptr_last_lp = ptr_w_lp'(resp_fifo_els_p - 1);

  msg_header_s         mem_r [resp_fifo_els_p];
  logic [ptr_w_lp-1:0] wptr_r;
  logic [ptr_w_lp-1:0] rptr_r;
  logic [cnt_w_lp-1:0] count_r;

  assign full_o = (count_r == cnt_w_lp'(resp_fifo_els_p));
  assign v_o    = (count_r != '0);
  assign hdr_o  = mem_r[rptr_r];

  always_ff @(posedge clk_i)
  begin
    if (push_i)
      mem_r[wptr_r] <= hdr_i;
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      wptr_r  <= '0;
      rptr_r  <= '0;
      count_r <= '0;
    end
    else
    begin
      if (push_i)
        wptr_r <= (wptr_r == ptr_last_lp) ? '0 : wptr_r + 1'b1;
      if (pop_i)
        rptr_r <= (rptr_r == ptr_last_lp) ? '0 : rptr_r + 1'b1;
      count_r <= count_r + cnt_w_lp'(push_i) - cnt_w_lp'(pop_i);
    end
  end

endmodule

`default_nettype wire

// ==== source/resp_pump_out.sv ====
// Response stream pump
`timescale 1ns/1ps
`default_nettype none

module resp_pump_out #(
  parameter int words_per_line_p = 8
) (
  input  wire                                  clk_i,
  input  wire                                  reset_i,
  input  bridge_pkg::msg_header_s              hdr_i,
  input  wire                                  hdr_v_i,
  output logic                                 hdr_pop_o,
  input  wire [bridge_pkg::data_width_c-1:0]   word_i,
  input  wire                                  word_v_i,
  output logic                                 word_yumi_o,
  output bridge_pkg::msg_header_s              resp_header_o,
  output logic [bridge_pkg::data_width_c-1:0]  resp_data_o,
  output logic                                 resp_v_o,
  output logic                                 resp_last_o,
  input  wire                                  resp_ready_and_i
);

  import bridge_pkg::*;

  localparam int cnt_w_lp = (words_per_line_p > 1) ? $clog2(words_per_line_p) : 1;
  localparam logic [cnt_w_lp-1:0] cnt_last_lp = cnt_w_lp'(words_per_line_p - 1);

  logic [cnt_w_lp-1:0]     cnt_r;
  logic                    is_block;
  logic                    wr_block;
  logic                    last_word;
  logic                    avail;
  logic [data_width_c-1:0] shifted;

  assign is_block  = (hdr_i.size == size_64);
  assign wr_block  = is_block && (hdr_i.msg_type == msg_wr);
  assign last_word = ~is_block | (cnt_r == cnt_last_lp);
  assign avail     = hdr_v_i & word_v_i;

  // a block write answers once, on its last word
  assign resp_v_o      = avail & (~wr_block | last_word);
  assign resp_last_o   = last_word;
  assign resp_header_o = hdr_i;
  assign word_yumi_o   = avail & (resp_ready_and_i | (wr_block & ~last_word));
  assign hdr_pop_o     = word_yumi_o & last_word;

  assign shifted = word_i >> {hdr_i.addr[word_off_c-1:0], 3'b000};

  // sub-word data lands at bit 0, zero extended
  always_comb
  begin
    case (hdr_i.size)
      size_1:  resp_data_o = data_width_c'(shifted[7:0]);
      size_2:  resp_data_o = data_width_c'(shifted[15:0]);
      size_4:  resp_data_o = data_width_c'(shifted[31:0]);
      default: resp_data_o = wr_block ? '0 : word_i;
    endcase
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      cnt_r <= '0;
    else if (word_yumi_o && is_block)
      cnt_r <= last_word ? '0 : cnt_r + 1'b1;
  end

endmodule

`default_nettype wire

// ==== testbench/mem_to_cache_properties.sv ====
// Bridge interface assertions
`timescale 1ns/1ps
`default_nettype none

module mem_to_cache_properties #(
  parameter int clear_num_p = 128
) (
  input wire                                 clk_i,
  input wire                                 reset_i,
  input wire bridge_pkg::msg_header_s        cmd_header_i,
  input wire                                 cmd_v_i,
  input wire                                 cmd_ready_i,
  input wire [bridge_pkg::data_width_c-1:0]  resp_data_i,
  input wire                                 resp_v_i,
  input wire                                 resp_ready_i,
  input wire                                 store_v_i,
  input wire                                 clear_yumi_i
);

  import bridge_pkg::*;

  int cleared_r;

  // clear responses are drained by the encoder itself
  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      cleared_r <= 0;
    else if (store_v_i && clear_yumi_i)
      cleared_r <= cleared_r + 1;
  end

  cmd_after_clear: assert property (@(posedge clk_i) disable iff (reset_i)
    (cmd_v_i && cmd_ready_i) |-> (cleared_r == clear_num_p))
    else $error("command accepted before the tag clear completed");

  resp_held_under_stall: assert property (@(posedge clk_i) disable iff (reset_i)
    (resp_v_i && !resp_ready_i) |=> (resp_v_i && $stable(resp_data_i)))
    else $error("response valid or data changed while stalled");

  no_lr_subop: assert property (@(posedge clk_i) disable iff (reset_i)
    cmd_v_i |-> (cmd_header_i.subop != subop_lr))
    else $error("command carries an LR sub-operation");

endmodule

bind mem_to_cache_top mem_to_cache_properties #(
  .clear_num_p(num_lines_p * words_per_line_p)
) mem_to_cache_properties_inst (
  .clk_i       (clk_i),
  .reset_i     (reset_i),
  .cmd_header_i(cmd_header_i),
  .cmd_v_i     (cmd_v_i),
  .cmd_ready_i (cmd_ready_and_o),
  .resp_data_i (resp_data_o),
  .resp_v_i    (resp_v_o),
  .resp_ready_i(resp_ready_and_i),
  .store_v_i   (store_v),
  .clear_yumi_i(clear_yumi)
);

`default_nettype wire

// ==== testbench/mem_to_cache_tb.sv ====
// Memory to cache bridge testbench
`timescale 1ns/1ps
`default_nettype none

module mem_to_cache_tb;

  import bridge_pkg::*;

  localparam int clk_period_c     = 4;
  localparam int num_lines_c      = 16;
  localparam int resp_fifo_els_c  = 4;
  localparam int words_per_line_c = 8;
  localparam int mem_bytes_c      = num_lines_c * words_per_line_c * 8;
  localparam int rounds_c         = 4;
  // block beats are counted like commands
  localparam int num_cmds_c       = 5 + rounds_c * 8 + 16 + rounds_c * 3 + 8;
  localparam int clear_cycles_c   = num_lines_c * words_per_line_c + 16;
  localparam int timeout_ns_c     = (clear_cycles_c + 40 * num_cmds_c) * 2 * clk_period_c;

  typedef struct packed {
    msg_header_s             header;
    logic [data_width_c-1:0] data;
    logic                    last;
  } resp_beat_s;

  logic                    clk;
  logic                    reset;
  msg_header_s             cmd_header;
  logic [data_width_c-1:0] cmd_data;
  logic                    cmd_v;
  logic                    cmd_last;
  logic                    cmd_ready_and;
  msg_header_s             resp_header;
  logic [data_width_c-1:0] resp_data;
  logic                    resp_v;
  logic                    resp_last;
  logic                    resp_ready_and;

  logic [7:0] ref_mem [mem_bytes_c];
  resp_beat_s exp_q [$];
  int         seed         = 69;
  int         stall_seed   = 69;
  logic       stall_en     = 1'b0;
  int         error_count  = 0;
  int         tests_run    = 0;
  int         tests_failed = 0;
  int         stall_cycles = 0;

  mem_to_cache_top #(
    .num_lines_p     (num_lines_c),
    .resp_fifo_els_p (resp_fifo_els_c),
    .words_per_line_p(words_per_line_c)
  ) mem_to_cache_top_inst (
    .clk_i           (clk),
    .reset_i         (reset),
    .cmd_header_i    (cmd_header),
    .cmd_data_i      (cmd_data),
    .cmd_v_i         (cmd_v),
    .cmd_last_i      (cmd_last),
    .cmd_ready_and_o (cmd_ready_and),
    .resp_header_o   (resp_header),
    .resp_data_o     (resp_data),
    .resp_v_o        (resp_v),
    .resp_last_o     (resp_last),
    .resp_ready_and_i(resp_ready_and)
  );

  initial
  begin
    clk = 1'b0;
    forever #(clk_period_c / 2) clk = ~clk;
  end

  // random byte offset inside a span, aligned to the access size
  function automatic int rand_offset(input int span, input int nbytes);
    int r;
    r = $random(seed);
    return (r & (span - 1)) & ~(nbytes - 1);
  endfunction

  function automatic logic [63:0] rand_word();
    return {$random(seed), $random(seed)};
  endfunction

  // little endian bytes, zero extended
  function automatic logic [63:0] ref_read(input int addr, input int nbytes);
    logic [63:0] val;
    val = '0;
    for (int i = 0; i < nbytes; i++)
      val[i*8 +: 8] = ref_mem[addr + i];
    return val;
  endfunction

  task automatic ref_write(input int addr, input int nbytes, input logic [63:0] val);
    for (int i = 0; i < nbytes; i++)
      ref_mem[addr + i] = val[i*8 +: 8];
  endtask

  task automatic expect_beat(input msg_header_s hdr, input logic [63:0] data,
                             input logic last);
    resp_beat_s b;
    b.header = hdr;
    b.data   = data;
    b.last   = last;
    exp_q.push_back(b);
  endtask

  // hold the beat until the bridge takes it
  task automatic send_beat(input msg_header_s hdr, input logic [63:0] data,
                           input logic last);
    cmd_header = hdr;
    cmd_data   = data;
    cmd_last   = last;
    cmd_v      = 1'b1;
    @(negedge clk);
    while (!cmd_ready_and)
      @(negedge clk);
    @(posedge clk);
    #1;
    cmd_v = 1'b0;
  endtask

  task automatic do_read(input int addr, input msg_size_e sz);
    msg_header_s hdr;
    int          base;
    hdr = msg_header_s'{msg_rd, subop_store, sz, addr_width_c'(addr)};
    if (sz == size_64)
    begin
      base = addr & ~(block_bytes_c - 1);
      for (int w = 0; w < block_words_c; w++)
        expect_beat(hdr, ref_read(base + 8 * w, 8), w == block_words_c - 1);
    end
    else
      expect_beat(hdr, ref_read(addr, 1 << sz), 1'b1);
    send_beat(hdr, '0, 1'b1);
  endtask

  // narrow stores answer with the old bytes they replace
  task automatic do_store(input int addr, input msg_size_e sz, input logic [63:0] data);
    msg_header_s hdr;
    int          nbytes;
    hdr    = msg_header_s'{msg_wr, subop_store, sz, addr_width_c'(addr)};
    nbytes = 1 << sz;
    expect_beat(hdr, ref_read(addr, nbytes), 1'b1);
    ref_write(addr, nbytes, data);
    send_beat(hdr, data, 1'b1);
  endtask

  task automatic do_block_write(input int base);
    msg_header_s hdr;
    logic [63:0] word;
    hdr = msg_header_s'{msg_wr, subop_store, size_64, addr_width_c'(base)};
    expect_beat(hdr, '0, 1'b1);
    for (int w = 0; w < block_words_c; w++)
    begin
      word = rand_word();
      ref_write(base + 8 * w, 8, word);
      send_beat(hdr, word, w == block_words_c - 1);
    end
  endtask

  task automatic do_amo(input int addr, input msg_subop_e op, input logic [63:0] data);
    msg_header_s hdr;
    logic [63:0] old;
    hdr = msg_header_s'{msg_amo, op, size_8, addr_width_c'(addr)};
    old = ref_read(addr, 8);
    expect_beat(hdr, old, 1'b1);
    ref_write(addr, 8, (op == subop_amoswap) ? data : old + data);
    send_beat(hdr, data, 1'b1);
  endtask

  task automatic report_test(input string name, input int since);
    int errs;
    while (exp_q.size() != 0)
    begin
      @(posedge clk);
      #1;
    end
    errs = error_count - since;
    tests_run++;
    if (errs != 0)
      tests_failed++;
    $display("%s: done, %0d errors", name, errs);
  endtask

  // response side, random back-pressure once stalls are on
  initial
  begin : response_check
    resp_beat_s want;
    resp_ready_and = 1'b1;
    forever
    begin
      @(posedge clk);
      #1;
      resp_ready_and = stall_en ? (($random(stall_seed) & 3) != 0) : 1'b1;
      @(negedge clk);
      if (resp_v && !resp_ready_and)
        stall_cycles++;
      if (resp_v && resp_ready_and)
      begin
        if (exp_q.size() == 0)
        begin
          $display("response beat at %0t arrived with no command waiting for it", $time);
          error_count++;
        end
        else
        begin
          want = exp_q.pop_front();
          assert (resp_header == want.header && resp_data == want.data &&
                  resp_last == want.last)
          else
          begin
            $display("ERR %0t: got hdr %h data %h last %b, expected hdr %h data %h last %b",
                     $time, resp_header, resp_data, resp_last,
                     want.header, want.data, want.last);
            error_count++;
          end
        end
      end
    end
  end

  initial
  begin : watchdog
    #(timeout_ns_c);
    $display("timeout: the bridge stopped answering before all tests finished");
    $display("Test failed");
    $finish;
  end

  initial
  begin : stimulus
    int mark;
    int stall_mark;
    int addr;
    int block;
    reset      = 1'b1;
    cmd_header = '0;
    cmd_data   = '0;
    cmd_v      = 1'b0;
    cmd_last   = 1'b0;
    for (int i = 0; i < mem_bytes_c; i++)
      ref_mem[i] = 8'h00;
    repeat (16) @(posedge clk);
    #1;
    reset = 1'b0;
    assert (!cmd_ready_and && !resp_v)
    else
    begin
      $display("ERR %0t: bridge not idle after reset", $time);
      error_count++;
    end

    // commands wait out the tag clear, then read back zero
    mark = error_count;
    do_read(rand_offset(mem_bytes_c, 1), size_1);
    do_read(rand_offset(mem_bytes_c, 2), size_2);
    do_read(rand_offset(mem_bytes_c, 4), size_4);
    do_read(rand_offset(mem_bytes_c, 8), size_8);
    do_read(rand_offset(mem_bytes_c, 64), size_64);
    report_test("test 1 clear and zero reads", mark);

    stall_en   = 1'b1;
    stall_mark = error_count;
    mark       = error_count;
    repeat (rounds_c)
    begin
      for (int s = 0; s < 4; s++)
      begin
        addr = rand_offset(mem_bytes_c, 1 << s);
        do_store(addr, msg_size_e'(s), rand_word());
        do_read(addr & ~7, size_8);
      end
    end
    report_test("test 2 narrow stores", mark);

    mark  = error_count;
    block = rand_offset(mem_bytes_c, block_bytes_c);
    do_block_write(block);
    do_read(block, size_64);
    report_test("test 3 block write and read", mark);

    // sub-word loads inside the freshly written block
    mark = error_count;
    repeat (rounds_c)
    begin
      do_read(block + rand_offset(block_bytes_c, 1), size_1);
      do_read(block + rand_offset(block_bytes_c, 2), size_2);
      do_read(block + rand_offset(block_bytes_c, 4), size_4);
    end
    report_test("test 4 sub-word reads", mark);

    mark = error_count;
    repeat (2)
    begin
      addr = block + rand_offset(block_bytes_c, 8);
      do_amo(addr, subop_amoswap, rand_word());
      do_read(addr, size_8);
      do_amo(addr, subop_amoadd, rand_word());
      do_read(addr, size_8);
    end
    report_test("test 5 swap and add", mark);

    stall_en = 1'b0;
    // back-pressure only counts if some response was really held
    if (stall_cycles == 0)
    begin
      $display("no response beat was ever stalled during tests 2 to 5");
      error_count++;
    end
    report_test($sformatf("test 6 stalls over tests 2 to 5 (%0d stalled cycles)",
                          stall_cycles), stall_mark);

    $display("%0d tests, %0d failed, %0d errors", tests_run, tests_failed, error_count);
    if (error_count == 0)
      $display("Test passed");
    else
      $display("Test failed");
    $finish;
  end

endmodule

`default_nettype wire
